/* hdl/decode_lane.sv */
`include "frontend_defines.svh"

module decode_lane import rv_frontend_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  inst_if.sink      inst_in,
  decoded_if.source dec_out
);

  lane_state_e state;
  inst_t       inst;
  funct3_t     f3;
  logic [6:0]  f7;
  op_class_e   cls;
  xlen_t       imm;
  logic        legal;

  assign inst = inst_in.inst;
  assign f3   = inst[14:12];
  assign f7   = inst[31:25];

  always_comb begin
    case (inst[6:0])
      opc_lui:      cls = op_lui;
      opc_auipc:    cls = op_auipc;
      opc_jal:      cls = op_jal;
      opc_jalr:     cls = op_jalr;
      opc_branch:   cls = op_branch;
      opc_load:     cls = op_load;
      opc_store:    cls = op_store;
      opc_op_imm:   cls = op_op_imm;
      opc_op:       cls = op_op;
      opc_imm_32:   cls = op_imm_32;
      opc_op_32:    cls = op_op_32;
      opc_misc_mem: cls = op_misc_mem;
      opc_system:   cls = op_system;
      default:      cls = op_unknown;
    endcase
  end

  // immediate by format, sign from bit 31
  always_comb begin
    case (cls)
      op_jalr, op_load, op_op_imm, op_imm_32, op_misc_mem, op_system:
        imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
      op_store:
        imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
      op_branch:
        imm = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      op_lui, op_auipc:
        imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
      op_jal:
        imm = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        imm = '0;   // R type and unknown
    endcase
  end

  always_comb begin
    case (cls)
      op_unknown: legal = 1'b0;
      op_jalr:    legal = (f3 == 3'd0);
      op_branch:  legal = (f3 != 3'd2) && (f3 != 3'd3);
      op_load:    legal = (f3 != 3'd7);
      op_store:   legal = (f3 < 3'd4);
      op_op, op_op_32: begin
        if (f7 == 7'd32) begin
          legal = (f3 == 3'd0) || (f3 == 3'd5);   // sub, sra only
        end else begin
          legal = (f7 == 7'd0) || (f7 == 7'd1);
        end
      end
      default:    legal = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= l_idle;
      inst_in.ack <= 1'b0;
      dec_out.req <= 1'b0;
    end else begin
      if (inst_in.ack && !inst_in.req) begin
        inst_in.ack <= 1'b0;
      end
      case (state)
        l_idle: begin
          if (inst_in.req && !inst_in.ack) begin
            inst_in.ack <= 1'b1;
            state       <= l_hold;
          end
        end
        l_hold: begin
          if (!dec_out.req) begin
            dec_out.req <= 1'b1;
          end else if (dec_out.ack) begin
            dec_out.req <= 1'b0;
            state       <= l_wait_drop;
          end
        end
        l_wait_drop: if (!dec_out.ack) state <= l_idle;
        default: state <= l_idle;
      endcase
    end
  end

  // capture and decode in one go
  always_ff @(posedge clk) begin
    if (state == l_idle && inst_in.req && !inst_in.ack) begin
      dec_out.op_class <= cls;
      dec_out.rd       <= inst[11:7];
      dec_out.rs1      <= inst[19:15];
      dec_out.rs2      <= inst[24:20];
      dec_out.funct3   <= f3;
      dec_out.imm      <= imm;
      dec_out.legal    <= legal;
      dec_out.pc       <= inst_in.pc;
    end
  end

endmodule

/* hdl/fetch_unit.sv */
`include "frontend_defines.svh"

module fetch_unit import rv_frontend_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  xlen_t       entry,
  input  logic        arready,
  input  fetch_word_t rdata,
  input  logic        rlast,
  input  logic        rvalid,
  output xlen_t       araddr,
  output logic        arvalid,
  output logic        rready,
  inst_if.source      lanes [`NUM_LANES]
);

  fetch_state_e          state;
  xlen_t                 pc;
  xlen_t                 word_pc;   // address of the word in word
  fetch_word_t           word;
  logic                  lane_req;
  logic [`NUM_LANES-1:0] lane_ack;

  // pc only moves on address acceptance, so araddr stays put while arvalid
  assign araddr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= f_addr;
      pc       <= entry;
      arvalid  <= 1'b0;
      rready   <= 1'b0;
      lane_req <= 1'b0;
    end else begin
      case (state)
        f_addr: begin
          if (!arvalid) begin
            arvalid <= 1'b1;
          end else if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            pc      <= pc + xlen_t'(`FETCH_STEP);
            state   <= f_data;
          end
        end
        f_data: begin
          if (rvalid && rlast) begin   // single beat, always the last
            rready   <= 1'b0;
            lane_req <= 1'b1;
            state    <= f_hand;
          end
        end
        f_hand: begin
          if (&lane_ack) begin
            lane_req <= 1'b0;
            state    <= f_wait_ack;
          end
        end
        f_wait_ack: begin
          // every lane must release before the next address goes out
          if (lane_ack == '0) begin
            state <= f_addr;
          end
        end
        default: state <= f_addr;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == f_addr && arvalid && arready) begin
      word_pc <= pc;
    end
    if (state == f_data && rvalid) begin
      word <= rdata;
    end
  end

  // split the word, lane i gets instruction i
  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    assign lanes[i].req  = lane_req;
    assign lanes[i].inst = word[i*`INST_W +: `INST_W];
    assign lanes[i].pc   = word_pc + xlen_t'(i * (`INST_W / 8));
    assign lane_ack[i]   = lanes[i].ack;
  end

endmodule

/* hdl/frontend_ifs.sv */
// fetch to one decode lane
interface inst_if import rv_frontend_pkg::*;;

  logic  req;
  logic  ack;
  inst_t inst;
  xlen_t pc;   // address of this instruction

  modport source (output req, inst, pc, input ack);
  modport sink   (input req, inst, pc, output ack);

endinterface

// decode lane to issue collector
interface decoded_if import rv_frontend_pkg::*;;

  logic      req;
  logic      ack;
  op_class_e op_class;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  funct3_t   funct3;
  xlen_t     imm;
  logic      legal;
  xlen_t     pc;

  modport source (output req, op_class, rd, rs1, rs2, funct3, imm, legal, pc, input ack);
  modport sink   (input req, op_class, rd, rs1, rs2, funct3, imm, legal, pc, output ack);

endinterface

/* hdl/issue_collector.sv */
`include "frontend_defines.svh"

module issue_collector import rv_frontend_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  decoded_if.sink   lanes [`NUM_LANES],
  output logic      dec_req,
  output xlen_t     dec_pc,
  output op_class_e dec_class,
  output reg_addr_t dec_rd,
  output reg_addr_t dec_rs1,
  output reg_addr_t dec_rs2,
  output funct3_t   dec_funct3,
  output xlen_t     dec_imm,
  output logic      dec_legal,
  input  logic      dec_ack
);

  localparam int PTR_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;

  collect_state_e        state;
  logic [PTR_W-1:0]      ptr;       // lane holding the oldest instruction
  logic                  lane_ack;
  logic [`NUM_LANES-1:0] lane_req;
  op_class_e             lane_class [`NUM_LANES];
  reg_addr_t             lane_rd [`NUM_LANES];
  reg_addr_t             lane_rs1 [`NUM_LANES];
  reg_addr_t             lane_rs2 [`NUM_LANES];
  funct3_t               lane_f3 [`NUM_LANES];
  xlen_t                 lane_imm [`NUM_LANES];
  logic                  lane_legal [`NUM_LANES];
  xlen_t                 lane_pc [`NUM_LANES];

  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    assign lane_req[i]   = lanes[i].req;
    assign lane_class[i] = lanes[i].op_class;
    assign lane_rd[i]    = lanes[i].rd;
    assign lane_rs1[i]   = lanes[i].rs1;
    assign lane_rs2[i]   = lanes[i].rs2;
    assign lane_f3[i]    = lanes[i].funct3;
    assign lane_imm[i]   = lanes[i].imm;
    assign lane_legal[i] = lanes[i].legal;
    assign lane_pc[i]    = lanes[i].pc;
    assign lanes[i].ack  = lane_ack && (ptr == PTR_W'(i));
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= c_wait_lane;
      ptr      <= '0;
      lane_ack <= 1'b0;
      dec_req  <= 1'b0;
    end else begin
      case (state)
        c_wait_lane: begin
          if (lane_req[ptr]) begin
            dec_req <= 1'b1;
            state   <= c_present;
          end
        end
        c_present: begin
          if (dec_ack) begin
            dec_req  <= 1'b0;
            lane_ack <= 1'b1;
            state    <= c_wait_drop;
          end
        end
        c_wait_drop: begin
          if (!lane_req[ptr] && !dec_ack) begin
            lane_ack <= 1'b0;
            ptr      <= (ptr == PTR_W'(`NUM_LANES - 1)) ? '0 : ptr + 1'b1;
            state    <= c_wait_lane;
          end
        end
        default: state <= c_wait_lane;
      endcase
    end
  end

  // output copy, held until the next lane is taken
  always_ff @(posedge clk) begin
    if (state == c_wait_lane && lane_req[ptr]) begin
      dec_pc     <= lane_pc[ptr];
      dec_class  <= lane_class[ptr];
      dec_rd     <= lane_rd[ptr];
      dec_rs1    <= lane_rs1[ptr];
      dec_rs2    <= lane_rs2[ptr];
      dec_funct3 <= lane_f3[ptr];
      dec_imm    <= lane_imm[ptr];
      dec_legal  <= lane_legal[ptr];
    end
  end

endmodule

/* hdl/rv_frontend_pkg.sv */
`include "frontend_defines.svh"

package rv_frontend_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`INST_W-1:0]     inst_t;
  typedef logic [`XLEN-1:0]       fetch_word_t;  // one beat, two instructions
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [2:0]             funct3_t;

  typedef enum logic [3:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_branch,
    op_load,
    op_store,
    op_op_imm,
    op_op,
    op_imm_32,
    op_op_32,
    op_misc_mem,
    op_system,
    op_unknown
  } op_class_e;

  typedef enum logic [1:0] {
    f_addr,
    f_data,
    f_hand,     // req up on all lanes
    f_wait_ack
  } fetch_state_e;

  typedef enum logic [1:0] {
    l_idle,
    l_hold,
    l_wait_drop
  } lane_state_e;

  typedef enum logic [1:0] {
    c_wait_lane,
    c_present,
    c_wait_drop
  } collect_state_e;

  // major opcodes
  localparam logic [6:0] opc_lui      = 7'b0110111;
  localparam logic [6:0] opc_auipc    = 7'b0010111;
  localparam logic [6:0] opc_jal      = 7'b1101111;
  localparam logic [6:0] opc_jalr     = 7'b1100111;
  localparam logic [6:0] opc_branch   = 7'b1100011;
  localparam logic [6:0] opc_load     = 7'b0000011;
  localparam logic [6:0] opc_store    = 7'b0100011;
  localparam logic [6:0] opc_op_imm   = 7'b0010011;
  localparam logic [6:0] opc_op       = 7'b0110011;
  localparam logic [6:0] opc_imm_32   = 7'b0011011;
  localparam logic [6:0] opc_op_32    = 7'b0111011;
  localparam logic [6:0] opc_misc_mem = 7'b0001111;
  localparam logic [6:0] opc_system   = 7'b1110011;

endpackage

/* hdl/rv_frontend_top.sv */
`include "frontend_defines.svh"

module rv_frontend_top import rv_frontend_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  xlen_t       entry,
  // AXI read, single beat
  output xlen_t       araddr,
  output logic        arvalid,
  input  logic        arready,
  input  fetch_word_t rdata,
  input  logic        rlast,
  input  logic        rvalid,
  output logic        rready,
  // decoded instruction out
  output logic        dec_req,
  input  logic        dec_ack,
  output xlen_t       dec_pc,
  output op_class_e   dec_class,
  output reg_addr_t   dec_rd,
  output reg_addr_t   dec_rs1,
  output reg_addr_t   dec_rs2,
  output funct3_t     dec_funct3,
  output xlen_t       dec_imm,
  output logic        dec_legal
);

  inst_if    inst_bus [`NUM_LANES] ();
  decoded_if dec_bus  [`NUM_LANES] ();

  fetch_unit u_fetch (
    .clk     (clk),
    .reset   (reset),
    .entry   (entry),
    .arready (arready),
    .rdata   (rdata),
    .rlast   (rlast),
    .rvalid  (rvalid),
    .araddr  (araddr),
    .arvalid (arvalid),
    .rready  (rready),
    .lanes   (inst_bus)
  );

  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    decode_lane u_lane (
      .clk     (clk),
      .reset   (reset),
      .inst_in (inst_bus[i]),
      .dec_out (dec_bus[i])
    );
  end

  issue_collector u_collect (
    .clk        (clk),
    .reset      (reset),
    .lanes      (dec_bus),
    .dec_req    (dec_req),
    .dec_pc     (dec_pc),
    .dec_class  (dec_class),
    .dec_rd     (dec_rd),
    .dec_rs1    (dec_rs1),
    .dec_rs2    (dec_rs2),
    .dec_funct3 (dec_funct3),
    .dec_imm    (dec_imm),
    .dec_legal  (dec_legal),
    .dec_ack    (dec_ack)
  );

endmodule

/* include/frontend_defines.svh */
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// data and address width
`define XLEN 64

`define INST_W 32

// register index width
`define REG_ADDR_W 5

`define NUM_LANES 2   // instructions per fetched word

// pc step per accepted read, in bytes
`define FETCH_STEP 8

`endif

/* project.f */
+incdir+include
hdl/rv_frontend_pkg.sv
hdl/frontend_ifs.sv
hdl/fetch_unit.sv
hdl/decode_lane.sv
hdl/issue_collector.sv
hdl/rv_frontend_top.sv
verification/frontend_assert.sv
verification/tb_checker.sv
verification/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

rm -rf "$build_dir"

if ! verilator --binary --timing --assert -f project.f --top-module tb_top \
    --Mdir "$build_dir" -o sim; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$log_file"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi

/* verification/frontend_assert.sv */
module frontend_assert import rv_frontend_pkg::*; (
  input logic      clk,
  input logic      reset,
  input xlen_t     araddr,
  input logic      arvalid,
  input logic      arready,
  input logic      rready,
  input logic      dec_req,
  input logic      dec_ack,
  input xlen_t     dec_pc,
  input op_class_e dec_class,
  input reg_addr_t dec_rd,
  input reg_addr_t dec_rs1,
  input reg_addr_t dec_rs2,
  input funct3_t   dec_funct3,
  input xlen_t     dec_imm,
  input logic      dec_legal
);
  timeunit 1ns;
  timeprecision 1ps;

  // read address held until accepted
  a_ar_hold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("read address dropped or changed before arready");

  a_dec_hold: assert property (@(posedge clk) disable iff (reset)
    dec_req && !dec_ack |=> dec_req)
    else $error("dec_req fell before dec_ack");

  a_dec_data: assert property (@(posedge clk) disable iff (reset)
    dec_req |=> !dec_req || $stable({dec_pc, dec_class, dec_rd, dec_rs1, dec_rs2,
                                     dec_funct3, dec_imm, dec_legal}))
    else $error("decoded data changed while dec_req high");

  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(rready && arvalid))
    else $error("rready high together with arvalid");

endmodule

bind rv_frontend_top frontend_assert u_assert (.*);

/* verification/tb_checker.sv */
module tb_checker import rv_frontend_pkg::*; #(
  parameter int num_words = 1
) (
  input logic        clk,
  input logic        reset,
  input xlen_t       entry,
  input fetch_word_t mem [num_words],
  input xlen_t       araddr,
  input logic        arvalid,
  input logic        arready,
  input logic        rvalid,
  input logic        rready,
  input logic        dec_req,
  input xlen_t       dec_pc,
  input op_class_e   dec_class,
  input reg_addr_t   dec_rd,
  input reg_addr_t   dec_rs1,
  input reg_addr_t   dec_rs2,
  input funct3_t     dec_funct3,
  input xlen_t       dec_imm,
  input logic        dec_legal
);
  timeunit 1ns;
  timeprecision 1ps;

  int   addr_count, beat_count, inst_count, legal_count, illegal_count;
  int   reset_errors, addr_errors, decode_errors, legal_errors, count_errors;
  logic last_reset = 1'b1;
  logic last_req = 1'b0;

  function automatic op_class_e opcode_class(input logic [6:0] opc);
    case (opc)
      7'h37:   return op_lui;
      7'h17:   return op_auipc;
      7'h6f:   return op_jal;
      7'h67:   return op_jalr;
      7'h63:   return op_branch;
      7'h03:   return op_load;
      7'h23:   return op_store;
      7'h13:   return op_op_imm;
      7'h33:   return op_op;
      7'h1b:   return op_imm_32;
      7'h3b:   return op_op_32;
      7'h0f:   return op_misc_mem;
      7'h73:   return op_system;
      default: return op_unknown;
    endcase
  endfunction

  // field packed at the top, arithmetic shift does the sign extension
  function automatic xlen_t format_imm(input inst_t ins, input op_class_e c);
    logic signed [63:0] v;
    case (c)
      op_jalr, op_load, op_op_imm, op_imm_32, op_misc_mem, op_system:
        v = $signed({ins[31:20], 52'h0}) >>> 52;
      op_store:
        v = $signed({ins[31:25], ins[11:7], 52'h0}) >>> 52;
      op_branch:
        v = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 51'h0}) >>> 51;
      op_lui, op_auipc:
        v = $signed({ins[31:12], 12'h0, 32'h0}) >>> 32;
      op_jal:
        v = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 43'h0}) >>> 43;
      default:
        v = '0;
    endcase
    return xlen_t'(v);
  endfunction

  function automatic logic legality(input inst_t ins, input op_class_e c);
    funct3_t    f3;
    logic [6:0] f7;
    logic       ok;
    f3 = ins[14:12];
    f7 = ins[31:25];
    ok = 1'b1;
    if (c == op_unknown) ok = 1'b0;
    if (c == op_jalr && f3 != 3'd0) ok = 1'b0;
    if (c == op_branch && (f3 == 3'd2 || f3 == 3'd3)) ok = 1'b0;
    if (c == op_load && f3 == 3'd7) ok = 1'b0;
    if (c == op_store && f3 >= 3'd4) ok = 1'b0;
    if (c == op_op || c == op_op_32) begin
      if (f7 != 7'd0 && f7 != 7'd32 && f7 != 7'd1) ok = 1'b0;
      if (f7 == 7'd32 && f3 != 3'd0 && f3 != 3'd5) ok = 1'b0;   // only sub and sra
    end
    return ok;
  endfunction

  function automatic int mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act, input xlen_t pc);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected 0x%h actual 0x%h at pc 0x%h", name, exp, act, pc);
      return 1;
    end
    return 0;
  endfunction

  task automatic compare_inst();
    xlen_t     exp_pc;
    inst_t     ins;
    op_class_e c;
    logic      lgl;
    if (inst_count >= 2 * num_words) begin
      $display("extra instruction issued at pc 0x%h", dec_pc);
      decode_errors++;
    end else begin
      ins = (inst_count % 2 == 1) ? mem[inst_count / 2][63:32] : mem[inst_count / 2][31:0];
      exp_pc = entry + xlen_t'(4 * inst_count);   // low half first
      c = opcode_class(ins[6:0]);
      lgl = legality(ins, c);
      decode_errors += mismatch("dec_pc", exp_pc, dec_pc, exp_pc);
      decode_errors += mismatch("dec_class", 64'(c), 64'(dec_class), exp_pc);
      decode_errors += mismatch("dec_rd", 64'(ins[11:7]), 64'(dec_rd), exp_pc);
      decode_errors += mismatch("dec_rs1", 64'(ins[19:15]), 64'(dec_rs1), exp_pc);
      decode_errors += mismatch("dec_rs2", 64'(ins[24:20]), 64'(dec_rs2), exp_pc);
      decode_errors += mismatch("dec_funct3", 64'(ins[14:12]), 64'(dec_funct3), exp_pc);
      decode_errors += mismatch("dec_imm", format_imm(ins, c), dec_imm, exp_pc);
      legal_errors += mismatch("dec_legal", 64'(lgl), 64'(dec_legal), exp_pc);
      if (lgl) legal_count++;
      else illegal_count++;
    end
    inst_count++;
  endtask

  always @(posedge clk) begin
    if (last_reset && !reset) begin
      reset_errors += mismatch("arvalid", '0, 64'(arvalid), entry);
      reset_errors += mismatch("rready", '0, 64'(rready), entry);
      reset_errors += mismatch("dec_req", '0, 64'(dec_req), entry);
      $display("test reset_state: %s", reset_errors == 0 ? "pass" : "fail");
    end
    if (!reset) begin
      if (arvalid && arready) begin
        addr_errors += mismatch("araddr", entry + xlen_t'(8 * addr_count), araddr, araddr);
        addr_count++;
      end
      if (rvalid && rready) beat_count++;
      if (dec_req && !last_req) compare_inst();
    end
    last_reset = reset;
    last_req = dec_req;
  end

  task automatic final_report(output int total);
    if (beat_count != num_words || inst_count != 2 * beat_count) begin
      $display("%0d instructions decoded for %0d read beats", inst_count, beat_count);
      count_errors++;
    end
    $display("test address_sequence: %0d addresses, %s", addr_count,
             addr_errors == 0 ? "pass" : "fail");
    $display("test decode_fields: %0d instructions, %s", inst_count,
             decode_errors == 0 ? "pass" : "fail");
    $display("test legality: %0d legal, %0d illegal, %s", legal_count, illegal_count,
             legal_errors == 0 ? "pass" : "fail");
    $display("test instruction_count: %0d beats, %0d decoded, %s", beat_count, inst_count,
             count_errors == 0 ? "pass" : "fail");
    total = reset_errors + addr_errors + decode_errors + legal_errors + count_errors;
    $display("errors: %0d total (reset %0d, address %0d, decode %0d, legal %0d, count %0d)",
             total, reset_errors, addr_errors, decode_errors, legal_errors, count_errors);
  endtask

endmodule

/* verification/tb_top.sv */
module tb_top import rv_frontend_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_words = 250;
  localparam int max_wait  = 1000;   // cycles per wait
  localparam logic [6:0] known_opc [13] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03,
                                            7'h23, 7'h13, 7'h33, 7'h1b, 7'h3b, 7'h0f, 7'h73};

  logic        clk = 1'b0;
  logic        reset;
  xlen_t       entry;
  xlen_t       araddr;
  logic        arvalid, arready;
  fetch_word_t rdata;
  logic        rlast, rvalid, rready;
  logic        dec_req, dec_ack, dec_legal;
  xlen_t       dec_pc, dec_imm;
  op_class_e   dec_class;
  reg_addr_t   dec_rd, dec_rs1, dec_rs2;
  funct3_t     dec_funct3;
  fetch_word_t mem [num_words];   // word returned for entry + 8 * index
  logic [31:0] inst_seed, bus_seed, ack_seed;
  int          total_errors;
  logic        timed_out = 1'b0;

  rv_frontend_top u_dut (.*);

  tb_checker #(.num_words(num_words)) u_chk (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // known opcode nine times in ten, op and op_32 mostly with a defined funct7
  function automatic inst_t random_inst();
    inst_t ins;
    inst_seed = xorshift(inst_seed);
    ins = inst_seed;
    inst_seed = xorshift(inst_seed);
    if (inst_seed % 10 != 0) ins[6:0] = known_opc[int'(inst_seed[15:8]) % 13];
    if ((ins[6:0] == 7'h33 || ins[6:0] == 7'h3b) && inst_seed[1:0] != 2'd0) begin
      ins[31:25] = (inst_seed[3:2] == 2'd0) ? 7'd32 : {6'd0, inst_seed[2]};
    end
    return ins;
  endfunction

  task automatic flag_timeout(input string what);
    $display("timeout while waiting for %s", what);
    timed_out = 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic serve_read();
    int    n;
    int    idx;
    xlen_t addr;
    n = 0;
    while (!arvalid && n < max_wait) begin
      @(negedge clk);
      n++;
    end
    if (!arvalid) begin
      flag_timeout("a read address");
      return;
    end
    bus_seed = xorshift(bus_seed);
    idle_cycles(bus_seed % 4);
    addr = araddr;
    idx = int'((addr - entry) >> 3);
    arready = 1'b1;
    @(negedge clk);
    arready = 1'b0;
    n = 0;
    while (!rready && n < max_wait) begin
      @(negedge clk);
      n++;
    end
    if (!rready) begin
      flag_timeout("rready");
      return;
    end
    bus_seed = xorshift(bus_seed);
    idle_cycles(bus_seed % 4);
    rdata = (idx >= 0 && idx < num_words) ? mem[idx] : ~addr;
    rvalid = 1'b1;   // single beat, so always last
    rlast = 1'b1;
    @(negedge clk);
    rvalid = 1'b0;
    rlast = 1'b0;
  endtask

  task automatic serve_ack();
    int n;
    n = 0;
    while (!dec_req && n < max_wait) begin
      @(negedge clk);
      n++;
    end
    if (!dec_req) begin
      flag_timeout("dec_req to rise");
      return;
    end
    ack_seed = xorshift(ack_seed);
    idle_cycles(ack_seed % 6);
    dec_ack = 1'b1;
    n = 0;
    while (dec_req && n < max_wait) begin
      @(negedge clk);
      n++;
    end
    if (dec_req) begin
      flag_timeout("dec_req to fall");
      return;
    end
    dec_ack = 1'b0;
  endtask

  initial begin
    inst_t lo, hi;
    reset = 1'b1;
    entry = 64'h0000_0040_8000_0000;
    arready = 1'b0;
    rdata = '0;
    rlast = 1'b0;
    rvalid = 1'b0;
    dec_ack = 1'b0;
    inst_seed = 32'd23561;
    for (int i = 0; i < num_words; i++) begin
      lo = random_inst();
      hi = random_inst();
      mem[i] = {hi, lo};
    end
    bus_seed = xorshift(inst_seed);
    ack_seed = xorshift(bus_seed);
    repeat (4) @(negedge clk);
    reset = 1'b0;
    fork
      for (int w = 0; w < num_words && !timed_out; w++) serve_read();
      for (int k = 0; k < 2 * num_words && !timed_out; k++) serve_ack();
    join
    idle_cycles(4);
    u_chk.final_report(total_errors);
    if (total_errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
